/* compile.f */
+incdir+source
source/rob_pkg.sv
source/rob_pointers.sv
source/rob_entries.sv
source/rob_commit.sv
source/rob_top.sv
test/rob_sva.sv
test/rob_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --top-module rob_tb -f compile.f -o rob_sim \
	> build.log 2>&1 \
	&& ./obj_dir/rob_sim > sim.log 2>&1 \
	&& ! grep -qF "*** TEST FAILED ***" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* source/rob_commit.sv */
// in-order retire selection over the three head entries
// commit packet build and the registered flush pulse
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_commit import rob_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  rob_entry_t        head_entries [`N_WAY],  // head, head+1, head+2
	output logic [`N_WAY-1:0] retire_mask,
	output retire_cnt_t       retire_cnt,
	output commit_packet_t    commit [`N_WAY],
	output logic              flush
);

	logic flush_next;

	//////////////////////////////
	// retire chain

	// a slot retires only behind a retired, correctly predicted older slot
	always_comb begin
		logic chain_ok;

		chain_ok   = !flush;         // nothing leaves during flush
		retire_cnt = '0;
		flush_next = 1'b0;
		for (int k = 0; k < `N_WAY; k++) begin
			retire_mask[k] = chain_ok && head_entries[k].valid && head_entries[k].done;
			chain_ok       = retire_mask[k] && !head_entries[k].mispredict;
			retire_cnt     = retire_cnt + retire_cnt_t'(retire_mask[k]);
			if (retire_mask[k] && head_entries[k].mispredict) begin
				flush_next = 1'b1;   // mispredict ends the group
			end
		end
	end

	//////////////////////////////
	// commit packets

	always_comb begin
		for (int k = 0; k < `N_WAY; k++) begin
			commit[k].valid      = retire_mask[k];
			commit[k].pc         = head_entries[k].inst.pc;
			commit[k].dest_tag   = head_entries[k].inst.dest_tag;
			commit[k].is_branch  = head_entries[k].inst.is_branch;
			commit[k].mispredict = head_entries[k].mispredict;
			commit[k].true_pc    = head_entries[k].true_pc;
		end
	end

	// one cycle pulse, since nothing retires while it is high
	always_ff @(posedge clock) begin
		if (reset) begin
			flush <= 1'b0;
		end else begin
			flush <= flush_next;
		end
	end

endmodule

/* source/rob_defines.svh */
// reorder buffer sizing macros
// entry count, index width, way count, address and tag widths
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

`define ROB_SIZE   16 // entries in the buffer
`define ROB_WIDTH  4  // log2 of ROB_SIZE
`define N_WAY      3  // dispatch, completion and retire width
`define XLEN       32 // pc and target width
`define TAG_WIDTH  6  // physical register tag

`endif

/* source/rob_entries.sv */
// reorder buffer entry array
// dispatch writes, completion and branch resolution, retire clearing and flush
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_entries import rob_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  dispatch_packet_t dispatch [`N_WAY],     // slot 0 oldest
	input  rob_idx_t         slot_idx [`N_WAY],
	input  rob_idx_t         head_idx [`N_WAY],
	input  cdb_packet_t      cdb [`N_WAY],
	input  branch_resolve_t  branch_resolve,
	input  logic [`N_WAY-1:0] retire_mask,
	input  logic             flush,
	output rob_entry_t       head_entries [`N_WAY],
	output retire_cnt_t      dispatch_cnt
);

	rob_entry_t entries      [`ROB_SIZE];
	rob_entry_t next_entries [`ROB_SIZE];

	// compares the resolved outcome with what fetch assumed
	function automatic logic is_mispredict(rob_entry_t e, branch_resolve_t br);
		if (e.inst.predict_taken) begin
			return !br.taken || (br.target != e.inst.predict_pc);
		end
		return br.taken;
	endfunction

	//////////////////////////////
	// next entry state

	always_comb begin
		for (int i = 0; i < `ROB_SIZE; i++) begin
			next_entries[i] = entries[i];

			for (int k = 0; k < `N_WAY; k++) begin
				if (cdb[k].valid && cdb[k].rob_idx == rob_idx_t'(i)) begin
					next_entries[i].done = 1'b1;
				end
			end

			if (branch_resolve.valid && branch_resolve.rob_idx == rob_idx_t'(i)) begin
				next_entries[i].done       = 1'b1;
				next_entries[i].mispredict = is_mispredict(entries[i], branch_resolve);
				next_entries[i].true_pc    = branch_resolve.taken ? branch_resolve.target
				                                                  : entries[i].inst.npc;
			end

			for (int k = 0; k < `N_WAY; k++) begin
				if (retire_mask[k] && head_idx[k] == rob_idx_t'(i)) begin
					next_entries[i].valid = 1'b0; // slot freed at this edge
					next_entries[i].done  = 1'b0;
				end
			end

			// dispatch slots only land on free entries
			for (int k = 0; k < `N_WAY; k++) begin
				if (dispatch[k].valid && slot_idx[k] == rob_idx_t'(i)) begin
					next_entries[i].inst       = dispatch[k];
					next_entries[i].valid      = 1'b1;
					next_entries[i].done       = 1'b0;
					next_entries[i].mispredict = 1'b0;
					next_entries[i].true_pc    = dispatch[k].npc;
				end
			end
		end
	end

	//////////////////////////////
	// storage

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int i = 0; i < `ROB_SIZE; i++) begin
				entries[i].valid      <= 1'b0;
				entries[i].done       <= 1'b0;
				entries[i].mispredict <= 1'b0;
			end
		end else begin
			entries <= next_entries;
		end
	end

	always_comb begin
		dispatch_cnt = '0;
		for (int k = 0; k < `N_WAY; k++) begin
			head_entries[k] = entries[head_idx[k]];
			dispatch_cnt    = dispatch_cnt + retire_cnt_t'(dispatch[k].valid);
		end
		if (flush) begin
			dispatch_cnt = '0; // dispatches dropped during flush
		end
	end

endmodule

/* source/rob_pkg.sv */
// reorder buffer types
// index, count and address vectors plus the dispatch, cdb, branch, entry and commit structs
`include "rob_defines.svh"

package rob_pkg;

	typedef logic [`ROB_WIDTH-1:0] rob_idx_t;
	typedef logic [`ROB_WIDTH:0]   rob_count_t;  // 0 .. ROB_SIZE
	typedef logic [`XLEN-1:0]      addr_t;
	typedef logic [`TAG_WIDTH-1:0] prf_tag_t;
	typedef logic [1:0]            retire_cnt_t; // 0 .. N_WAY per cycle

	//////////////////////////////
	// packets at the boundary

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		addr_t    npc;           // fall-through pc
		logic     is_branch;
		logic     predict_taken;
		addr_t    predict_pc;    // predicted target
		prf_tag_t dest_tag;
	} dispatch_packet_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
	} cdb_packet_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		logic     taken;
		addr_t    target;
	} branch_resolve_t;

	//////////////////////////////
	// stored entry and retire output

	typedef struct packed {
		logic             valid;
		logic             done;
		logic             mispredict;
		addr_t            true_pc;   // where fetch should have gone
		dispatch_packet_t inst;
	} rob_entry_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		prf_tag_t dest_tag;
		logic     is_branch;
		logic     mispredict;
		addr_t    true_pc;
	} commit_packet_t;

endpackage

/* source/rob_pointers.sv */
// head, tail and occupancy registers
// slot and head index generation, free entry count
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_pointers import rob_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  retire_cnt_t dispatch_cnt,          // slots written this cycle
	input  retire_cnt_t retire_cnt,            // entries leaving this cycle
	input  logic        flush,
	output rob_idx_t    slot_idx [`N_WAY],     // tail, tail+1, tail+2
	output rob_idx_t    head_idx [`N_WAY],     // head, head+1, head+2
	output rob_count_t  free_count
);

	rob_idx_t   head;
	rob_idx_t   tail;
	rob_count_t occupancy;

	//////////////////////////////
	// pointer registers

	// size is a power of two so the index adds wrap on their own
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head      <= '0;
			tail      <= '0;
			occupancy <= '0;
		end else begin
			head      <= head + rob_idx_t'(retire_cnt);
			tail      <= tail + rob_idx_t'(dispatch_cnt);
			occupancy <= occupancy + rob_count_t'(dispatch_cnt)
			             - rob_count_t'(retire_cnt);
		end
	end

	//////////////////////////////
	// consecutive indices

	always_comb begin
		for (int k = 0; k < `N_WAY; k++) begin
			slot_idx[k] = tail + rob_idx_t'(k); // modulo ROB_SIZE
			head_idx[k] = head + rob_idx_t'(k);
		end
	end

	assign free_count = rob_count_t'(`ROB_SIZE) - occupancy;

endmodule

/* source/rob_top.sv */
// reorder buffer top level
// pointer, entry and commit blocks
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_top import rob_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  dispatch_packet_t dispatch [`N_WAY],
	input  cdb_packet_t      cdb [`N_WAY],
	input  branch_resolve_t  branch_resolve,
	output rob_idx_t         rob_num [`N_WAY],     // indices for dispatch slots
	output rob_count_t       free_count,
	output commit_packet_t   commit [`N_WAY],
	output logic             flush
);

	rob_idx_t          head_idx     [`N_WAY];
	rob_entry_t        head_entries [`N_WAY];
	retire_cnt_t       dispatch_cnt;
	retire_cnt_t       retire_cnt;
	logic [`N_WAY-1:0] retire_mask;

	rob_pointers i_pointers (
		.clock        (clock),
		.reset        (reset),
		.dispatch_cnt (dispatch_cnt),
		.retire_cnt   (retire_cnt),
		.flush        (flush),
		.slot_idx     (rob_num),
		.head_idx     (head_idx),
		.free_count   (free_count)
	);

	rob_entries i_entries (
		.clock          (clock),
		.reset          (reset),
		.dispatch       (dispatch),
		.slot_idx       (rob_num),
		.head_idx       (head_idx),
		.cdb            (cdb),
		.branch_resolve (branch_resolve),
		.retire_mask    (retire_mask),
		.flush          (flush),
		.head_entries   (head_entries),
		.dispatch_cnt   (dispatch_cnt)
	);

	rob_commit i_commit (
		.clock        (clock),
		.reset        (reset),
		.head_entries (head_entries),
		.retire_mask  (retire_mask),
		.retire_cnt   (retire_cnt),
		.commit       (commit),
		.flush        (flush)
	);

endmodule

/* test/rob_sva.sv */
// concurrent checks bound to the reorder buffer top level
// commit ordering, flush pulse and free count rules
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_sva import rob_pkg::*; (
	input logic           clock,
	input logic           reset,
	input commit_packet_t commit [`N_WAY],
	input logic           flush,
	input rob_count_t     free_count
);

	logic [`N_WAY-1:0] commit_valid;

	always_comb begin
		for (int k = 0; k < `N_WAY; k++) begin
			commit_valid[k] = commit[k].valid;
		end
	end

	a_reset_state: assert property (@(posedge clock)
		$fell(reset) |-> (free_count == rob_count_t'(`ROB_SIZE) && !flush && commit_valid == '0))
		else $error("state after reset is wrong");

	// valids form a run from slot 0
	a_contiguous: assert property (@(posedge clock) disable iff (reset)
		(!commit_valid[1] || commit_valid[0]) && (!commit_valid[2] || commit_valid[1]))
		else $error("commit valids are not contiguous");

	a_no_commit_in_flush: assert property (@(posedge clock) disable iff (reset)
		flush |-> commit_valid == '0)
		else $error("commit during flush");

	a_flush_pulse: assert property (@(posedge clock) disable iff (reset) flush |=> !flush)
		else $error("flush longer than one cycle");

	a_flush_empties: assert property (@(posedge clock) disable iff (reset)
		flush |=> free_count == rob_count_t'(`ROB_SIZE))
		else $error("buffer not empty after flush");

	a_free_bound: assert property (@(posedge clock) disable iff (reset)
		free_count <= rob_count_t'(`ROB_SIZE))
		else $error("free_count above buffer size");

endmodule

bind rob_top rob_sva i_sva (
	.clock      (clock),
	.reset      (reset),
	.commit     (commit),
	.flush      (flush),
	.free_count (free_count)
);

/* test/rob_tb.sv */
// testbench for the reorder buffer top level
// LFSR stimulus, queue model with immediate checks, watchdog
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_tb import rob_pkg::*; ();

	localparam int CLOCK_PERIOD   = 100;
	localparam int RESET_CYCLES   = 16;
	localparam int TEST_CYCLES    = 2000;              // random phase plus drain allowance
	localparam int RANDOM_CYCLES  = TEST_CYCLES - 100;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic             clock;
	logic             reset;
	dispatch_packet_t dispatch [`N_WAY];
	cdb_packet_t      cdb [`N_WAY];
	branch_resolve_t  branch_resolve;
	rob_idx_t         rob_num [`N_WAY];
	rob_count_t       free_count;
	commit_packet_t   commit [`N_WAY];
	logic             flush;

	rob_entry_t        model_rob [`ROB_SIZE];      // reference queue, same indexing
	rob_idx_t          model_head;
	rob_idx_t          model_tail;
	int                model_occ;
	logic              model_flush;
	logic [`N_WAY-1:0] retire_now;                 // expected retire this cycle
	logic [31:0]       lfsr_state;
	addr_t             next_pc;

	rob_top i_dut (.*);

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		logic        feedback;

		value = '0;
		for (int i = 0; i < n; i++) begin
			feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value      = {value[30:0], feedback};
		end
		return value;
	endfunction

	task automatic fail_check(input string msg);
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic clear_model();
		for (int i = 0; i < `ROB_SIZE; i++) begin
			model_rob[i] = '0;
		end
		model_head  = '0;
		model_tail  = '0;
		model_occ   = 0;
		model_flush = 1'b0;
	endtask

	//////////////////////////////
	// compare outputs with the model

	task automatic check_outputs();
		logic       chain;
		rob_entry_t e;

		assert (flush == model_flush && free_count == rob_count_t'(`ROB_SIZE - model_occ))
			else fail_check($sformatf("flush %b free_count %0d, model expects %b and %0d",
				flush, free_count, model_flush, `ROB_SIZE - model_occ));
		chain = !model_flush;                        // nothing retires in the flush cycle
		for (int k = 0; k < `N_WAY; k++) begin
			e             = model_rob[model_head + rob_idx_t'(k)];
			retire_now[k] = chain && e.valid && e.done;
			chain         = retire_now[k] && !e.mispredict;  // mispredict closes the group
			assert (rob_num[k] == model_tail + rob_idx_t'(k))
				else fail_check($sformatf("rob_num[%0d] is %0d", k, rob_num[k]));
			assert (commit[k].valid == retire_now[k] && (!retire_now[k] ||
				{commit[k].pc, commit[k].dest_tag, commit[k].is_branch, commit[k].mispredict,
				 commit[k].true_pc} == {e.inst.pc, e.inst.dest_tag, e.inst.is_branch,
				 e.mispredict, e.true_pc}))
				else fail_check($sformatf("commit[%0d] valid %b pc %h, model expects %b pc %h",
					k, commit[k].valid, commit[k].pc, retire_now[k], e.inst.pc));
		end
	endtask

	//////////////////////////////
	// stimulus and model update

	task automatic drive_cycle(input logic allow_dispatch);
		int         n;
		int         retired;
		rob_idx_t   idx;
		rob_entry_t e;

		n = allow_dispatch ? int'(random_bits(2)) : 0;
		n = (n > `ROB_SIZE - model_occ) ? `ROB_SIZE - model_occ : n;
		branch_resolve = '0;
		for (int k = 0; k < `N_WAY; k++) begin
			dispatch[k] = '0;
			cdb[k]      = '0;
			if (k < n) begin
				dispatch[k].valid         = 1'b1;
				dispatch[k].pc            = next_pc;
				dispatch[k].npc           = next_pc + 32'd4;
				dispatch[k].is_branch     = random_bits(2) == 0;  // about one in four
				dispatch[k].predict_taken = random_bits(1) != 0;
				dispatch[k].predict_pc    = addr_t'(random_bits(16)) << 2;
				dispatch[k].dest_tag      = prf_tag_t'(random_bits(`TAG_WIDTH));
				next_pc                   = next_pc + 32'd4;
			end
			idx = rob_idx_t'(random_bits(`ROB_WIDTH));
			e   = model_rob[idx];
			if (e.valid && !e.done && !e.inst.is_branch && random_bits(1) != 0) begin
				cdb[k].valid   = 1'b1;                // out of order completion
				cdb[k].rob_idx = idx;
			end
		end
		idx = rob_idx_t'(random_bits(`ROB_WIDTH));
		e   = model_rob[idx];
		if (e.valid && !e.done && e.inst.is_branch) begin
			branch_resolve.valid   = 1'b1;
			branch_resolve.rob_idx = idx;
			branch_resolve.taken   = random_bits(1) != 0;
			branch_resolve.target  = (random_bits(1) != 0) ? e.inst.predict_pc
			                                               : addr_t'(random_bits(16)) << 2;
		end
		if (model_flush) begin
			clear_model();                           // dispatches dropped, buffer empties
			return;
		end
		for (int k = 0; k < `N_WAY; k++) begin
			if (cdb[k].valid) begin
				model_rob[cdb[k].rob_idx].done = 1'b1;
			end
		end
		if (branch_resolve.valid) begin
			e      = model_rob[branch_resolve.rob_idx];
			e.done = 1'b1;
			// a taken prediction also has to get the target right
			e.mispredict = e.inst.predict_taken
				? (!branch_resolve.taken || branch_resolve.target != e.inst.predict_pc)
				: branch_resolve.taken;
			e.true_pc = branch_resolve.taken ? branch_resolve.target : e.inst.npc;
			model_rob[branch_resolve.rob_idx] = e;
		end
		retired = 0;
		for (int k = 0; k < `N_WAY; k++) begin
			if (retire_now[k]) begin
				idx                  = model_head + rob_idx_t'(k);
				model_flush          = model_flush || model_rob[idx].mispredict;
				model_rob[idx].valid = 1'b0;
				retired++;
			end
		end
		model_head = model_head + rob_idx_t'(retired);
		for (int k = 0; k < n; k++) begin
			model_rob[model_tail + rob_idx_t'(k)] = '{valid: 1'b1, done: 1'b0, mispredict: 1'b0,
				true_pc: dispatch[k].npc, inst: dispatch[k]};
		end
		model_tail = model_tail + rob_idx_t'(n);
		model_occ  = model_occ + n - retired;
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		reset          = 1'b1;
		branch_resolve = '0;
		for (int k = 0; k < `N_WAY; k++) begin
			dispatch[k] = '0;
			cdb[k]      = '0;
		end
		lfsr_state = 32'hf7194f4a;
		next_pc    = 32'h0000_1000;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			check_outputs();                         // outputs settled since the rising edge
			drive_cycle(1'b1);
			@(negedge clock);
		end
		// no more dispatch, run until the buffer is empty
		while (model_occ != 0 || model_flush) begin
			check_outputs();
			drive_cycle(1'b0);
			@(negedge clock);
		end
		check_outputs();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("watchdog expired after %0d cycles, the buffer never drained", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

endmodule
